// ==== verilog/dispatch_pkg.sv ====
/* Dispatch sizes and types */

package dispatch_pkg;

  // ------------------------------------------------------------------
  // Sizes
  // ------------------------------------------------------------------

  // Number of requesters feeding the dispatcher
  localparam int NUM_REQ = 6;

  // Number of issue lanes, which also caps the grants made in one cycle
  localparam int MAX_GRANT = 3;

  // Depth of the credit pool shared by all lanes
  localparam int CREDIT_MAX = 4;

  // Width of one command word
  localparam int CMD_W = 16;

  // Enough bits to name any of the six requesters
  localparam int REQ_IDX_W = 3;

  // Holds a grant count or allowance from 0 up to MAX_GRANT
  localparam int GNT_CNT_W = 2;

  // Holds a credit count from 0 up to CREDIT_MAX
  localparam int CREDIT_W = 3;

  // ------------------------------------------------------------------
  // Types
  // ------------------------------------------------------------------
  typedef logic [CMD_W-1:0]     cmd_t;
  typedef logic [REQ_IDX_W-1:0] req_idx_t;
  typedef logic [NUM_REQ-1:0]   req_vec_t;
  typedef logic [GNT_CNT_W-1:0] gnt_cnt_t;

endpackage

// ==== verilog/rr_prio_enc.sv ====
/* Rotating multi-result priority encoder */

module rr_prio_enc import dispatch_pkg::*; (
  input  logic                       clk,
  input  logic                       rst_n,
  input  req_vec_t                   in_req,
  input  req_vec_t                   lowest_prio,
  output req_vec_t [MAX_GRANT-1:0]   out_grants
);

  req_idx_t                 lp_idx;
  req_idx_t                 start_idx;
  req_vec_t                 rot_req;
  req_vec_t [MAX_GRANT-1:0] rot_pick;

  // Turn the one-hot lowest priority marker into a binary index
  always_comb begin
    lp_idx = '0;
    for (int i = 0; i < NUM_REQ; i++) begin
      if (lowest_prio[i]) lp_idx = req_idx_t'(i);
    end
  end

  // The search begins one above the lowest priority index and wraps at NUM_REQ
  assign start_idx = (lp_idx == req_idx_t'(NUM_REQ - 1)) ? '0 : lp_idx + 1'b1;

  // Rotate right so the highest priority requester lands on bit 0
  assign rot_req = req_vec_t'({in_req, in_req} >> start_idx);

  // Peel off the lowest set bit once per result slot
  always_comb begin
    req_vec_t remaining;
    remaining = rot_req;
    for (int j = 0; j < MAX_GRANT; j++) begin
      // Two's complement trick isolates the lowest one
      rot_pick[j] = remaining & (~remaining + req_vec_t'(1));
      remaining   = remaining & ~rot_pick[j];
    end
  end

  // Rotate each pick left by the same amount to return to requester numbering
  always_comb begin
    logic [2*NUM_REQ-1:0] wide;
    for (int j = 0; j < MAX_GRANT; j++) begin
      wide          = {rot_pick[j], rot_pick[j]} << start_idx;
      out_grants[j] = wide[2*NUM_REQ-1:NUM_REQ];
    end
  end

  // ------------------------------------------------------------------
  // Assertions
  // ------------------------------------------------------------------
  for (genvar j = 0; j < MAX_GRANT; j++) begin : g_slot_chk
    slot_onehot0_a: assert property (@(posedge clk) disable iff (!rst_n)
      $onehot0(out_grants[j]));
    for (genvar k = j + 1; k < MAX_GRANT; k++) begin : g_pair_chk
      // Two slots never name the same requester
      slot_disjoint_a: assert property (@(posedge clk) disable iff (!rst_n)
        (out_grants[j] & out_grants[k]) == '0);
    end
  end

  // The priority register upstream must always hold exactly one marker
  lowest_prio_onehot_a: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot(lowest_prio));

endmodule

// ==== verilog/multi_rr_arb.sv ====
/* Multi-grant round-robin arbiter */

module multi_rr_arb import dispatch_pkg::*; (
  input  logic                      clk,
  input  logic                      rst_n,
  input  req_vec_t                  request,
  input  gnt_cnt_t                  grant_allowed,
  input  logic                      prio_update_en,
  output req_vec_t                  grant,
  output req_vec_t [MAX_GRANT-1:0]  grant_ordered,
  output gnt_cnt_t                  grant_count
);

  // ------------------------------------------------------------------
  // Candidate grants
  // ------------------------------------------------------------------
  req_vec_t [MAX_GRANT-1:0]       all_grants;
  logic     [MAX_GRANT-1:0]       slot_valid;
  logic     [$clog2(NUM_REQ+1)-1:0] req_count;
  gnt_cnt_t                       last_sel;
  req_vec_t                       lowest_prio;
  req_vec_t                       lowest_prio_next;
  logic                           prio_update;

  // The encoder hands back the first MAX_GRANT requesters in rotating order
  rr_prio_enc u_prio_enc (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_req      (request),
    .lowest_prio (lowest_prio),
    .out_grants  (all_grants)
  );

  // Unary decode of the allowance, filling from slot 0 upward
  // An allowance of 2 opens slots 0 and 1 and keeps slot 2 shut
  for (genvar j = 0; j < MAX_GRANT; j++) begin : g_slot_valid
    assign slot_valid[j]    = grant_allowed > gnt_cnt_t'(j);
    assign grant_ordered[j] = slot_valid[j] ? all_grants[j] : '0;
  end

  // Merge the ordered view into a flat grant vector
  always_comb begin
    grant = '0;
    for (int j = 0; j < MAX_GRANT; j++) begin
      grant = grant | grant_ordered[j];
    end
  end

  // ------------------------------------------------------------------
  // Grant count
  // ------------------------------------------------------------------

  // Population count of the request vector
  always_comb begin
    req_count = '0;
    for (int i = 0; i < NUM_REQ; i++) begin
      req_count = req_count + request[i];
    end
  end

  // Grants are limited by whichever is smaller, demand or allowance
  assign grant_count = (req_count <= grant_allowed) ? gnt_cnt_t'(req_count) : grant_allowed;

  // ------------------------------------------------------------------
  // Priority state
  // ------------------------------------------------------------------

  // The last granted slot becomes the new lowest priority
  assign last_sel         = grant_count - 1'b1;
  assign lowest_prio_next = grant_ordered[last_sel];

  // Only move the pointer when allowed and something was actually granted
  assign prio_update = prio_update_en && (grant_count != '0);

  // Index NUM_REQ-1 starts as lowest, so index 0 wins first
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lowest_prio <= {1'b1, {(NUM_REQ - 1){1'b0}}};
    end else if (prio_update) begin
      lowest_prio <= lowest_prio_next;
    end
  end

  // ------------------------------------------------------------------
  // Assertions
  // ------------------------------------------------------------------

  // The credit block must never offer more grants than there are lanes
  allowed_in_range_a: assert property (@(posedge clk) disable iff (!rst_n)
    grant_allowed <= gnt_cnt_t'(MAX_GRANT));

  // Flat grant and reported count agree, so lanes and credits see the same number
  grant_count_match_a: assert property (@(posedge clk) disable iff (!rst_n)
    $countones(grant) == grant_count);

  // A grant only goes to a requester that is asking
  grant_subset_a: assert property (@(posedge clk) disable iff (!rst_n)
    (grant & ~request) == '0);

endmodule

// ==== verilog/issue_credit_ctrl.sv ====
/* Issue credit pool */

module issue_credit_ctrl import dispatch_pkg::*; (
  input  logic                clk,
  input  logic                rst_n,
  input  gnt_cnt_t            grant_count,
  input  logic                credit_return,
  output gnt_cnt_t            grant_allowed,
  output logic [CREDIT_W-1:0] credits
);

  logic [CREDIT_W-1:0] credits_next;

  // ------------------------------------------------------------------
  // Credit counter
  // ------------------------------------------------------------------

  // Issued commands consume credits and a return pulse gives one back
  // The arbiter never grants past the allowance, so this cannot go negative
  assign credits_next = credits - CREDIT_W'(grant_count) + CREDIT_W'(credit_return);

  // The pool starts full
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      credits <= CREDIT_W'(CREDIT_MAX);
    end else begin
      credits <= credits_next;
    end
  end

  // ------------------------------------------------------------------
  // Allowance
  // ------------------------------------------------------------------

  // Saturate to the lane count, since the pool can be deeper than the lanes
  // A returned credit only shows up here once it is in the register
  assign grant_allowed = (credits >= CREDIT_W'(MAX_GRANT)) ? gnt_cnt_t'(MAX_GRANT)
                                                           : gnt_cnt_t'(credits);

  // ------------------------------------------------------------------
  // Assertions
  // ------------------------------------------------------------------

  // Counter stays within the pool size over any sequence of grants and returns
  credits_bound_a: assert property (@(posedge clk) disable iff (!rst_n)
    credits <= CREDIT_W'(CREDIT_MAX));

  // The consumer cannot hand back a credit that was never taken
  no_return_when_full_a: assert property (@(posedge clk) disable iff (!rst_n)
    credit_return |-> (credits < CREDIT_W'(CREDIT_MAX)));

endmodule

// ==== verilog/issue_lane_stage.sv ====
/* Issue lane output registers */

module issue_lane_stage import dispatch_pkg::*; (
  input  logic                      clk,
  input  logic                      rst_n,
  input  req_vec_t [MAX_GRANT-1:0]  grant_ordered,
  input  cmd_t     [NUM_REQ-1:0]    cmd_in,
  output logic     [MAX_GRANT-1:0]  lane_valid,
  output cmd_t     [MAX_GRANT-1:0]  lane_cmd,
  output req_idx_t [MAX_GRANT-1:0]  lane_src
);

  logic     [MAX_GRANT-1:0] slot_hit;
  req_idx_t [MAX_GRANT-1:0] slot_idx;
  cmd_t     [MAX_GRANT-1:0] slot_cmd;

  // ------------------------------------------------------------------
  // Per-lane select
  // ------------------------------------------------------------------

  // Each slot is one-hot or empty, so ORing the set positions gives its index
  always_comb begin
    for (int j = 0; j < MAX_GRANT; j++) begin
      slot_idx[j] = '0;
      for (int i = 0; i < NUM_REQ; i++) begin
        if (grant_ordered[j][i]) slot_idx[j] = slot_idx[j] | req_idx_t'(i);
      end
    end
  end

  for (genvar j = 0; j < MAX_GRANT; j++) begin : g_lane_sel
    assign slot_hit[j] = |grant_ordered[j];
    // Pick the command of the requester that owns this slot
    assign slot_cmd[j] = cmd_in[slot_idx[j]];
  end

  // ------------------------------------------------------------------
  // Lane registers
  // ------------------------------------------------------------------

  // Valid is a single-cycle pulse per grant
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lane_valid <= '0;
    end else begin
      lane_valid <= slot_hit;
    end
  end

  // Payload only loads on a grant and otherwise keeps its last value
  always_ff @(posedge clk) begin
    for (int j = 0; j < MAX_GRANT; j++) begin
      if (slot_hit[j]) begin
        lane_cmd[j] <= slot_cmd[j];
        lane_src[j] <= slot_idx[j];
      end
    end
  end

  // Lanes fill from lane 0 because the arbiter packs grants in priority order
  for (genvar j = 1; j < MAX_GRANT; j++) begin : g_lane_chk
    lane_contiguous_a: assert property (@(posedge clk) disable iff (!rst_n)
      lane_valid[j] |-> lane_valid[j-1]);
  end

endmodule

// ==== verilog/multi_issue_dispatch.sv ====
/* Multi-issue dispatcher top level */

module multi_issue_dispatch import dispatch_pkg::*; (
  input  logic                      clk,
  input  logic                      rst_n,
  input  req_vec_t                  request,
  input  cmd_t     [NUM_REQ-1:0]    cmd_in,
  input  logic                      prio_update_en,
  input  logic                      credit_return,
  output req_vec_t                  grant,
  output gnt_cnt_t                  grant_count,
  output logic     [MAX_GRANT-1:0]  lane_valid,
  output cmd_t     [MAX_GRANT-1:0]  lane_cmd,
  output req_idx_t [MAX_GRANT-1:0]  lane_src,
  output logic     [CREDIT_W-1:0]   credits
);

  // Allowance from the credit pool into the arbiter
  gnt_cnt_t                 grant_allowed;
  // Grants in priority order, one slot per lane
  req_vec_t [MAX_GRANT-1:0] grant_ordered;

  // ------------------------------------------------------------------
  // Arbitration
  // ------------------------------------------------------------------
  multi_rr_arb u_arb (
    .clk            (clk),
    .rst_n          (rst_n),
    .request        (request),
    .grant_allowed  (grant_allowed),
    .prio_update_en (prio_update_en),
    .grant          (grant),
    .grant_ordered  (grant_ordered),
    .grant_count    (grant_count)
  );

  // Grant count feeds back here and is charged at the next edge
  issue_credit_ctrl u_credit (
    .clk           (clk),
    .rst_n         (rst_n),
    .grant_count   (grant_count),
    .credit_return (credit_return),
    .grant_allowed (grant_allowed),
    .credits       (credits)
  );

  // ------------------------------------------------------------------
  // Output lanes
  // ------------------------------------------------------------------
  issue_lane_stage u_lanes (
    .clk           (clk),
    .rst_n         (rst_n),
    .grant_ordered (grant_ordered),
    .cmd_in        (cmd_in),
    .lane_valid    (lane_valid),
    .lane_cmd      (lane_cmd),
    .lane_src      (lane_src)
  );

endmodule

// ==== verif/tb_multi_issue_dispatch.sv ====
/* Dispatcher testbench */

module tb_multi_issue_dispatch import dispatch_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int TEST_CYC    = 400;
  localparam int NUM_TESTS   = 5;
  localparam int TIMEOUT_CYC = NUM_TESTS * TEST_CYC + 100;

  logic                      clk;
  logic                      rst_n;
  req_vec_t                  request;
  cmd_t     [NUM_REQ-1:0]    cmd_in;
  logic                      prio_update_en;
  logic                      credit_return;
  req_vec_t                  grant;
  gnt_cnt_t                  grant_count;
  logic     [MAX_GRANT-1:0]  lane_valid;
  cmd_t     [MAX_GRANT-1:0]  lane_cmd;
  req_idx_t [MAX_GRANT-1:0]  lane_src;
  logic     [CREDIT_W-1:0]   credits;

  // Traffic shape of the running test, with rates in percent per cycle
  bit active;
  int p_req;
  int p_ret;
  int p_upd;
  bit cont_mode;
  bit toggle_mode;
  bit fair_mode;
  int max_wait;

  // Reference model of pointer, credit pool and lane registers
  int                   m_lp;
  int                   m_credits;
  int                   outstanding[$];
  logic [MAX_GRANT-1:0] exp_valid;
  cmd_t                 exp_cmd[MAX_GRANT];
  int                   exp_src[MAX_GRANT];
  req_vec_t             granted_last;
  req_vec_t             prev_req;
  req_vec_t             prev_grant;
  bit                   prev_en;
  int                   prev_allowed;
  int                   wait_grants[NUM_REQ];
  int                   age[NUM_REQ];
  int                   test_err;
  int                   n_pass;
  int                   n_fail;
  int                   cycles;

  multi_issue_dispatch dut0 (
    .clk            (clk),
    .rst_n          (rst_n),
    .request        (request),
    .cmd_in         (cmd_in),
    .prio_update_en (prio_update_en),
    .credit_return  (credit_return),
    .grant          (grant),
    .grant_count    (grant_count),
    .lane_valid     (lane_valid),
    .lane_cmd       (lane_cmd),
    .lane_src       (lane_src),
    .credits        (credits)
  );

  always #5 clk = ~clk;

  // Ends the run once it outlasts the total test length
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > TIMEOUT_CYC) begin
      $display("Run timed out after %0d cycles", cycles);
      $display("Simulation failed");
      $finish;
    end
  end

  task automatic report_mismatch(input string msg);
    $display("FAIL @ %0d ns: %s", $time, msg);
    test_err++;
  endtask

  // ------------------------------------------------------------------
  // Stimulus driven on the rising edge
  // ------------------------------------------------------------------
  task automatic drive_inputs();
    req_vec_t next_req;
    next_req = request;
    for (int i = 0; i < NUM_REQ; i++) begin
      // A granted requester either drops or, under full load, issues a fresh command
      if (granted_last[i]) begin
        if (cont_mode) cmd_in[i] <= cmd_t'($urandom);
        else next_req[i] = 1'b0;
      end
      if (!next_req[i] && ($urandom_range(99) < p_req)) begin
        next_req[i] = 1'b1;
        cmd_in[i] <= cmd_t'($urandom);
      end
    end
    request <= next_req;
    // Returns only while the consumer holds credits
    credit_return <= (outstanding.size() > 0) && ($urandom_range(99) < p_ret);
    if (toggle_mode) begin
      if ($urandom_range(99) < p_upd) prio_update_en <= ~prio_update_en;
    end else begin
      prio_update_en <= ($urandom_range(99) < p_upd);
    end
  endtask

  // All random draws come from this process
  initial begin
    void'($urandom(32'h71cb));
    forever begin
      @(posedge clk);
      if (active) drive_inputs();
    end
  end

  // ------------------------------------------------------------------
  // Reference model and checks on the falling edge
  // ------------------------------------------------------------------
  task automatic init_model();
    m_lp         = NUM_REQ - 1;
    m_credits    = CREDIT_MAX;
    outstanding.delete();
    exp_valid    = '0;
    granted_last = '0;
    prev_en      = 1'b1;
    for (int i = 0; i < NUM_REQ; i++) age[i] = 0;
  endtask

  task automatic check_cycle();
    int       allowed;
    int       cnt;
    int       idx;
    int       picks[$];
    req_vec_t exp_grant;
    exp_grant = '0;
    allowed   = (m_credits < MAX_GRANT) ? m_credits : MAX_GRANT;
    // Walk upward from just above the lowest priority index
    for (int k = 1; k <= NUM_REQ; k++) begin
      idx = (m_lp + k) % NUM_REQ;
      if (request[idx] && (picks.size() < allowed)) begin
        picks.push_back(idx);
        exp_grant[idx] = 1'b1;
      end
    end
    cnt = picks.size();
    if (grant !== exp_grant)
      report_mismatch($sformatf("grant %b, expected %b", grant, exp_grant));
    if (grant_count !== gnt_cnt_t'(cnt))
      report_mismatch($sformatf("grant_count %0d, expected %0d", grant_count, cnt));
    if (credits !== CREDIT_W'(m_credits))
      report_mismatch($sformatf("credits %0d, expected %0d", credits, m_credits));
    if (credits == '0 && grant != '0)
      report_mismatch("grant made with zero credits");
    if (!prev_en && request == prev_req && allowed == prev_allowed && grant !== prev_grant)
      report_mismatch($sformatf("grant moved to %b with priority frozen", grant));
    for (int j = 0; j < MAX_GRANT; j++) begin
      if (lane_valid[j] !== exp_valid[j])
        report_mismatch($sformatf("lane %0d valid %b, expected %b", j, lane_valid[j],
                                  exp_valid[j]));
      else if (exp_valid[j] && (lane_cmd[j] !== exp_cmd[j] ||
                                lane_src[j] !== req_idx_t'(exp_src[j])))
        report_mismatch($sformatf("lane %0d carries %h from %0d, expected %h from %0d", j,
                                  lane_cmd[j], lane_src[j], exp_cmd[j], exp_src[j]));
    end
    for (int i = 0; i < NUM_REQ; i++) begin
      // Under full load no index sees more than NUM_REQ-1 other grants in a row
      if (grant[i]) wait_grants[i] = 0;
      else if (request[i]) wait_grants[i] += int'(grant_count);
      if (fair_mode && wait_grants[i] > NUM_REQ - 1)
        report_mismatch($sformatf("requester %0d passed over %0d times", i, wait_grants[i]));
      age[i] = (request[i] && !grant[i]) ? age[i] + 1 : 0;
      if (max_wait > 0 && age[i] == max_wait + 1)
        report_mismatch($sformatf("requester %0d waiting over %0d cycles", i, max_wait));
    end
    // Advance the model to the state the DUT holds after the next edge
    for (int j = 0; j < MAX_GRANT; j++) begin
      exp_valid[j] = (j < cnt);
      if (j < cnt) begin
        exp_cmd[j] = cmd_in[picks[j]];
        exp_src[j] = picks[j];
        outstanding.push_back(picks[j]);
      end
    end
    if (credit_return && outstanding.size() > 0) void'(outstanding.pop_front());
    m_credits    = m_credits - cnt + int'(credit_return);
    if (prio_update_en && cnt > 0) m_lp = picks[cnt-1];
    granted_last = exp_grant;
    prev_req     = request;
    prev_grant   = grant;
    prev_en      = prio_update_en;
    prev_allowed = allowed;
  endtask

  always @(negedge clk) begin
    if (!rst_n) init_model();
    else check_cycle();
  end

  // ------------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------------
  task automatic run_test(input int num, input string name, input int req_pct,
                          input int ret_pct, input int upd_pct, input bit cont,
                          input bit toggle, input bit fair, input int wait_lim);
    p_req       = req_pct;
    p_ret       = ret_pct;
    p_upd       = upd_pct;
    cont_mode   = cont;
    toggle_mode = toggle;
    fair_mode   = fair;
    max_wait    = wait_lim;
    for (int i = 0; i < NUM_REQ; i++) wait_grants[i] = 0;
    // Tally a little after the last rising edge of the test
    repeat (TEST_CYC) @(posedge clk);
    #2;
    if (test_err == 0) n_pass++;
    else n_fail++;
    $display("Test %0d %s finished with %0d errors", num, name, test_err);
    test_err = 0;
  endtask

  initial begin
    clk            = 1'b0;
    rst_n          = 1'b0;
    request        = '0;
    cmd_in         = '0;
    prio_update_en = 1'b0;
    credit_return  = 1'b0;
    active         = 1'b0;
    cycles         = 0;
    test_err       = 0;
    n_pass         = 0;
    n_fail         = 0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    #2;
    active = 1'b1;
    run_test(1, "full_load_fairness", 100, 90, 100, 1'b1, 1'b0, 1'b1, 0);
    run_test(2, "credit_backpressure", 50, 5, 100, 1'b0, 1'b0, 1'b0, 0);
    run_test(3, "frozen_priority", 3, 60, 5, 1'b1, 1'b1, 1'b0, 0);
    run_test(4, "lane_contents", 60, 50, 70, 1'b0, 1'b0, 1'b0, 0);
    run_test(5, "sparse_mixed", 8, 60, 50, 1'b0, 1'b0, 1'b0, 150);
    active = 1'b0;
    $display("Tests passed: %0d, failed: %0d", n_pass, n_fail);
    if (n_fail == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== multi_issue_dispatch.f ====
verilog/dispatch_pkg.sv
verilog/rr_prio_enc.sv
verilog/multi_rr_arb.sv
verilog/issue_credit_ctrl.sv
verilog/issue_lane_stage.sv
verilog/multi_issue_dispatch.sv
verif/tb_multi_issue_dispatch.sv
